// ==== design/commit_buffer.sv ====
// BUFFER_DEPTH must be a power of two of at least 2; the caller never writes when full
`timescale 1ns/100ps
`default_nettype none

module commit_buffer
    import exec_pkg::*;
#(
    parameter int BUFFER_DEPTH = 8
) (
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       flush_i,

    // Commands
    input  logic       write_i,
    input  logic       read_i,

    // Write side, from the ALU
    input  data_word_t result_i,
    input  reg_idx_t   rd_i,
    input  rob_tag_t   tag_i,

    // Head of the buffer
    output data_word_t result_o,
    output reg_idx_t   rd_o,
    output rob_tag_t   tag_o,

    // Forwarding lookups by source register
    input  reg_idx_t   fwd_src_i [2],
    output data_word_t fwd_data_o [2],
    output logic       fwd_valid_o [2],

    // Status
    output logic       full_o,
    output logic       empty_o
);

    localparam int PTR_W = $clog2(BUFFER_DEPTH);

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr_inc;
    logic [PTR_W-1:0] rd_ptr_inc;

    // ========================================================================
    // Pointers and status
    // ========================================================================

    // Pointers wrap by themselves, which is why the depth is a power of two
    assign wr_ptr_inc = wr_ptr + 1'b1;
    assign rd_ptr_inc = rd_ptr + 1'b1;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (write_i) begin
                wr_ptr <= wr_ptr_inc;
            end
            if (read_i) begin
                rd_ptr <= rd_ptr_inc;
            end
        end
    end

    // Status is registered; a read together with a write leaves it unchanged
    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            full_o  <= 1'b0;
            empty_o <= 1'b1;
        end else begin
            case ({write_i, read_i})
                2'b01: begin
                    full_o  <= 1'b0;
                    empty_o <= (wr_ptr == rd_ptr_inc);
                end
                2'b10: begin
                    empty_o <= 1'b0;
                    full_o  <= (rd_ptr == wr_ptr_inc);
                end
                default: begin
                    full_o  <= full_o;
                    empty_o <= empty_o;
                end
            endcase
        end
    end

    // ========================================================================
    // Result storage
    // ========================================================================

    data_word_t result_mem [BUFFER_DEPTH];
    reg_idx_t   rd_mem     [BUFFER_DEPTH];
    rob_tag_t   tag_mem    [BUFFER_DEPTH];

    always_ff @(posedge clk_i) begin
        if (write_i) begin
            result_mem[wr_ptr] <= result_i;
            rd_mem[wr_ptr]     <= rd_i;
            tag_mem[wr_ptr]    <= tag_i;
        end
    end

    assign result_o = result_mem[rd_ptr];
    assign rd_o     = rd_mem[rd_ptr];
    assign tag_o    = tag_mem[rd_ptr];

    // ========================================================================
    // Forward tables
    // ========================================================================

    // One entry per architectural register holds the youngest buffered value for it
    data_word_t          fwd_value [NUM_REGS];
    rob_tag_t            fwd_tag   [NUM_REGS];
    logic [NUM_REGS-1:0] fwd_valid;

    always_ff @(posedge clk_i) begin
        if (write_i) begin
            fwd_value[rd_i] <= result_i;
            fwd_tag[rd_i]   <= tag_i;
        end
    end

    // An entry goes stale when its last writer retires, since the register file then has it
    // A write in the same cycle wins, because it is younger than the retiring head
    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            fwd_valid <= '0;
        end else begin
            if (read_i && (fwd_tag[rd_o] == tag_o)) begin
                fwd_valid[rd_o] <= 1'b0;
            end
            if (write_i) begin
                fwd_valid[rd_i] <= 1'b1;
            end
        end
    end

    assign fwd_data_o[0]  = fwd_value[fwd_src_i[0]];
    assign fwd_data_o[1]  = fwd_value[fwd_src_i[1]];
    assign fwd_valid_o[0] = fwd_valid[fwd_src_i[0]];
    assign fwd_valid_o[1] = fwd_valid[fwd_src_i[1]];

    // The ALU holds its item on full and the top only retires a present head
    a_no_write_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(write_i && full_o));
    a_no_read_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(read_i && empty_o));

endmodule : commit_buffer

`default_nettype wire

// ==== design/exec_pkg.sv ====
// Shared types of the integer back end; the register count is fixed at 32 and tags wrap at 64
`default_nettype none

package exec_pkg;

    // ========================================================================
    // Data widths
    // ========================================================================

    // Operand and result width of the integer datapath
    typedef logic [31:0] data_word_t;

    // Architectural register index, x0 reads as zero everywhere
    typedef logic [4:0] reg_idx_t;

    // Issue-order tag; it wraps, so no more than 64 instructions may be in flight
    typedef logic [5:0] rob_tag_t;

    // ALU operation select, only codes 0 to 5 are legal
    typedef logic [2:0] alu_op_t;

    // Number of architectural registers, sizes the register file and the forward tables
    localparam int NUM_REGS = 32;

    // ========================================================================
    // ALU operation codes
    // ========================================================================

    localparam alu_op_t ALU_OP_ADD  = 3'd0;
    localparam alu_op_t ALU_OP_SUB  = 3'd1;
    localparam alu_op_t ALU_OP_AND  = 3'd2;
    localparam alu_op_t ALU_OP_OR   = 3'd3;
    localparam alu_op_t ALU_OP_XOR  = 3'd4;

    // ADDI adds the immediate to rs1; fetch puts the immediate on operand B
    localparam alu_op_t ALU_OP_ADDI = 3'd5;

endpackage : exec_pkg

`default_nettype wire

// ==== design/exec_top.sv ====
// BUFFER_DEPTH must be a power of two of at least 2; retire_en_i may drop at any cycle
`timescale 1ns/100ps
`default_nettype none

module exec_top
    import exec_pkg::*;
#(
    parameter int BUFFER_DEPTH = 8
) (
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       flush_i,

    // Issue side
    input  logic       instr_valid_i,
    input  alu_op_t    instr_op_i,
    input  reg_idx_t   instr_rd_i,
    input  reg_idx_t   instr_rs1_i,
    input  reg_idx_t   instr_rs2_i,
    input  data_word_t instr_imm_i,
    output logic       issue_ready_o,

    // Retire side
    input  logic       retire_en_i,
    output logic       retire_valid_o,
    output reg_idx_t   retire_rd_o,
    output rob_tag_t   retire_tag_o,
    output data_word_t retire_data_o
);

    // Fetch to execute
    logic       fet_valid;
    alu_op_t    fet_op;
    reg_idx_t   fet_rd;
    rob_tag_t   fet_tag;
    data_word_t fet_a;
    data_word_t fet_b;

    // Execute status, bypass and buffer write
    logic       alu_busy;
    logic       alu_valid;
    reg_idx_t   alu_rd;
    data_word_t alu_result;
    logic       buf_wr;
    rob_tag_t   buf_wr_tag;
    logic       buf_full;
    logic       buf_empty;

    // Operand lookups
    reg_idx_t   rf_raddr [2];
    data_word_t rf_rdata [2];
    reg_idx_t   fwd_src [2];
    data_word_t fwd_data [2];
    logic       fwd_valid [2];

    // ========================================================================
    // Pipeline stages
    // ========================================================================

    operand_fetch u_fetch (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .flush_i       (flush_i),
        .instr_valid_i (instr_valid_i),
        .instr_op_i    (instr_op_i),
        .instr_rd_i    (instr_rd_i),
        .instr_rs1_i   (instr_rs1_i),
        .instr_rs2_i   (instr_rs2_i),
        .instr_imm_i   (instr_imm_i),
        .issue_ready_o (issue_ready_o),
        .alu_busy_i    (alu_busy),
        .alu_valid_i   (alu_valid),
        .alu_rd_i      (alu_rd),
        .alu_result_i  (alu_result),
        .rf_raddr_o    (rf_raddr),
        .rf_rdata_i    (rf_rdata),
        .fwd_src_o     (fwd_src),
        .fwd_data_i    (fwd_data),
        .fwd_valid_i   (fwd_valid),
        .fet_valid_o   (fet_valid),
        .fet_op_o      (fet_op),
        .fet_rd_o      (fet_rd),
        .fet_tag_o     (fet_tag),
        .fet_a_o       (fet_a),
        .fet_b_o       (fet_b)
    );

    int_alu u_alu (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .flush_i      (flush_i),
        .fet_valid_i  (fet_valid),
        .fet_op_i     (fet_op),
        .fet_rd_i     (fet_rd),
        .fet_tag_i    (fet_tag),
        .fet_a_i      (fet_a),
        .fet_b_i      (fet_b),
        .buf_full_i   (buf_full),
        .alu_busy_o   (alu_busy),
        .alu_valid_o  (alu_valid),
        .alu_rd_o     (alu_rd),
        .alu_result_o (alu_result),
        .wr_o         (buf_wr),
        .wr_tag_o     (buf_wr_tag)
    );

    // The head is retired whenever one is present and the commit side allows it
    assign retire_valid_o = !buf_empty && retire_en_i;

    commit_buffer #(
        .BUFFER_DEPTH (BUFFER_DEPTH)
    ) u_commit (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .flush_i     (flush_i),
        .write_i     (buf_wr),
        .read_i      (retire_valid_o),
        .result_i    (alu_result),
        .rd_i        (alu_rd),
        .tag_i       (buf_wr_tag),
        .result_o    (retire_data_o),
        .rd_o        (retire_rd_o),
        .tag_o       (retire_tag_o),
        .fwd_src_i   (fwd_src),
        .fwd_data_o  (fwd_data),
        .fwd_valid_o (fwd_valid),
        .full_o      (buf_full),
        .empty_o     (buf_empty)
    );

    // Architectural state is written on the same edge the buffer head is released
    reg_file u_regs (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .raddr_i (rf_raddr),
        .rdata_o (rf_rdata),
        .we_i    (retire_valid_o),
        .waddr_i (retire_rd_o),
        .wdata_i (retire_data_o)
    );

endmodule : exec_top

`default_nettype wire

// ==== design/int_alu.sv ====
// Writes the commit buffer in the cycle it sees an item; a full buffer parks one item here
`timescale 1ns/100ps
`default_nettype none

module int_alu
    import exec_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       flush_i,

    // Item from operand fetch
    input  logic       fet_valid_i,
    input  alu_op_t    fet_op_i,
    input  reg_idx_t   fet_rd_i,
    input  rob_tag_t   fet_tag_i,
    input  data_word_t fet_a_i,
    input  data_word_t fet_b_i,

    input  logic       buf_full_i,
    output logic       alu_busy_o,

    // Current result, used as bypass and as buffer write data
    output logic       alu_valid_o,
    output reg_idx_t   alu_rd_o,
    output data_word_t alu_result_o,
    output logic       wr_o,
    output rob_tag_t   wr_tag_o
);

    logic       hold_valid;
    alu_op_t    hold_op;
    reg_idx_t   hold_rd;
    rob_tag_t   hold_tag;
    data_word_t hold_a;
    data_word_t hold_b;
    alu_op_t    cur_op;
    data_word_t cur_a;
    data_word_t cur_b;

    // A parked item is older than the fetch item, so it goes first
    assign alu_valid_o = hold_valid || fet_valid_i;
    assign cur_op      = hold_valid ? hold_op : fet_op_i;
    assign alu_rd_o    = hold_valid ? hold_rd : fet_rd_i;
    assign wr_tag_o    = hold_valid ? hold_tag : fet_tag_i;
    assign cur_a       = hold_valid ? hold_a : fet_a_i;
    assign cur_b       = hold_valid ? hold_b : fet_b_i;

    always_comb begin
        case (cur_op)
            ALU_OP_ADD, ALU_OP_ADDI: alu_result_o = cur_a + cur_b;
            ALU_OP_SUB:              alu_result_o = cur_a - cur_b;
            ALU_OP_AND:              alu_result_o = cur_a & cur_b;
            ALU_OP_OR:               alu_result_o = cur_a | cur_b;
            ALU_OP_XOR:              alu_result_o = cur_a ^ cur_b;
            default:                 alu_result_o = '0;
        endcase
    end

    assign wr_o = alu_valid_o && !buf_full_i;

    // Fetch waits while an item is parked, so the bypass never has to cover two items
    assign alu_busy_o = hold_valid;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            hold_valid <= 1'b0;
        end else if (!hold_valid) begin
            hold_valid <= fet_valid_i && buf_full_i;
        end else if (!buf_full_i) begin
            hold_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!hold_valid) begin
            hold_op  <= fet_op_i;
            hold_rd  <= fet_rd_i;
            hold_tag <= fet_tag_i;
            hold_a   <= fet_a_i;
            hold_b   <= fet_b_i;
        end
    end

    // Fetch and the issue side must only ever deliver the six defined operations
    a_legal_op: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        alu_valid_o |-> (cur_op <= ALU_OP_ADDI));

endmodule : int_alu

`default_nettype wire

// ==== design/operand_fetch.sv ====
// Issue inputs must hold while valid is high and ready is low; a flush drops the staged item
`timescale 1ns/100ps
`default_nettype none

module operand_fetch
    import exec_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       flush_i,

    // Issue side
    input  logic       instr_valid_i,
    input  alu_op_t    instr_op_i,
    input  reg_idx_t   instr_rd_i,
    input  reg_idx_t   instr_rs1_i,
    input  reg_idx_t   instr_rs2_i,
    input  data_word_t instr_imm_i,
    output logic       issue_ready_o,

    // ALU stage status and bypass
    input  logic       alu_busy_i,
    input  logic       alu_valid_i,
    input  reg_idx_t   alu_rd_i,
    input  data_word_t alu_result_i,

    // Register file and commit buffer lookups
    output reg_idx_t   rf_raddr_o [2],
    input  data_word_t rf_rdata_i [2],
    output reg_idx_t   fwd_src_o [2],
    input  data_word_t fwd_data_i [2],
    input  logic       fwd_valid_i [2],

    // Stage register towards the ALU
    output logic       fet_valid_o,
    output alu_op_t    fet_op_o,
    output reg_idx_t   fet_rd_o,
    output rob_tag_t   fet_tag_o,
    output data_word_t fet_a_o,
    output data_word_t fet_b_o
);

    reg_idx_t   src [2];
    data_word_t opnd [2];
    rob_tag_t   tag_cnt;
    logic       accept;

    assign src[0] = instr_rs1_i;
    assign src[1] = instr_rs2_i;

    // Both lookups use the raw source indices of the instruction on the issue port
    assign rf_raddr_o[0] = src[0];
    assign rf_raddr_o[1] = src[1];
    assign fwd_src_o[0]  = src[0];
    assign fwd_src_o[1]  = src[1];

    // ========================================================================
    // Operand resolution
    // ========================================================================

    // The ALU stage holds the youngest unwritten result, so it beats the buffer tables,
    // which in turn hold values the register file has not seen yet
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            if (src[i] == '0) begin
                opnd[i] = '0;
            end else if (alu_valid_i && (alu_rd_i == src[i])) begin
                opnd[i] = alu_result_i;
            end else if (fwd_valid_i[i]) begin
                opnd[i] = fwd_data_i[i];
            end else begin
                opnd[i] = rf_rdata_i[i];
            end
        end
    end

    // ========================================================================
    // Stage register
    // ========================================================================

    // The register takes a new item when it is empty or its item moves into the ALU
    assign issue_ready_o = !fet_valid_o || !alu_busy_i;
    assign accept        = instr_valid_i && issue_ready_o;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            fet_valid_o <= 1'b0;
            tag_cnt     <= '0;
        end else if (flush_i) begin
            // The tag counter keeps counting across a flush
            fet_valid_o <= 1'b0;
        end else begin
            if (issue_ready_o) begin
                fet_valid_o <= accept;
            end
            if (accept) begin
                tag_cnt <= tag_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            fet_op_o  <= instr_op_i;
            fet_rd_o  <= instr_rd_i;
            fet_tag_o <= tag_cnt;
            fet_a_o   <= opnd[0];
            // ADDI takes the immediate in place of rs2
            fet_b_o   <= (instr_op_i == ALU_OP_ADDI) ? instr_imm_i : opnd[1];
        end
    end

    // A stalled issue keeps its fields, otherwise the resolved operands go stale
    a_issue_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (instr_valid_i && !issue_ready_o) |=> (instr_valid_i && $stable(instr_op_i)
            && $stable(instr_rd_i) && $stable(instr_rs1_i) && $stable(instr_rs2_i)
            && $stable(instr_imm_i)));

endmodule : operand_fetch

`default_nettype wire

// ==== design/reg_file.sv ====
// Reads are combinational and see a retire write only from the next cycle; x0 stays zero
`timescale 1ns/100ps
`default_nettype none

module reg_file
    import exec_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_n_i,

    // Read ports for rs1 and rs2
    input  reg_idx_t   raddr_i [2],
    output data_word_t rdata_o [2],

    // Retire write port
    input  logic       we_i,
    input  reg_idx_t   waddr_i,
    input  data_word_t wdata_i
);

    data_word_t regs [NUM_REGS];

    // Entry 0 is cleared by reset and never written, so it keeps reading zero
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    assign rdata_o[0] = regs[raddr_i[0]];
    assign rdata_o[1] = regs[raddr_i[1]];

endmodule : reg_file

`default_nettype wire

// ==== files.f ====
design/exec_pkg.sv
design/operand_fetch.sv
design/int_alu.sv
design/commit_buffer.sv
design/reg_file.sv
design/exec_top.sv
tests/tb_clock_gen.sv
tests/tb_exec_top.sv

// ==== tests/exec_vectors.txt ====
# I op rd rs1 rs2 imm expected, all hex; op 0 ADD 1 SUB 2 AND 3 OR 4 XOR 5 ADDI
# H holds retire, R releases it, F pulses flush, W waits until all issued instructions retire
# Constants through ADDI from x0, then the register-register operations
I 5 01 00 00 00000007 00000007
I 5 02 00 00 00000003 00000003
I 0 03 01 02 00000000 0000000a
I 1 04 01 02 00000000 00000004
I 2 05 01 02 00000000 00000003
I 3 06 01 02 00000000 00000007
I 4 07 01 02 00000000 00000004
# Dependency chains at distance one and two, both sources
I 0 08 03 03 00000000 00000014
I 0 09 08 08 00000000 00000028
I 1 0a 09 08 00000000 00000014
I 4 0b 0a 09 00000000 0000003c
# x0 write retires with its data, a later read of x0 is zero
I 5 00 01 00 00000010 00000017
I 0 0c 00 01 00000000 00000007
W
# Back-pressure: ten are accepted with retire held, the eleventh waits for R
H
I 5 0d 0c 00 00000001 00000008
I 5 0e 0d 00 00000001 00000009
I 5 0f 0e 00 00000001 0000000a
I 5 10 0f 00 00000001 0000000b
I 5 11 10 00 00000001 0000000c
I 5 12 11 00 00000001 0000000d
I 5 13 12 00 00000001 0000000e
I 5 14 13 00 00000001 0000000f
I 5 15 14 00 00000001 00000010
I 5 16 15 00 00000001 00000011
I 5 17 16 00 00000001 00000012
R
W
# Flushed writes to x1 and x2 must not reach later readers
H
I 5 01 00 00 00000063 00000000
I 0 02 01 01 00000000 00000000
F
R
I 0 18 01 02 00000000 0000000a
I 0 19 18 0c 00000000 00000011
I 1 1a 19 18 00000000 00000007
I 3 1b 1a 19 00000000 00000017
W

// ==== tests/tb_clock_gen.sv ====
// Free-running clock; reset is held low for RESET_CYCLES rising edges and released on a falling edge
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 8
) (
    output logic clk_o,
    output logic rst_n_o
);

    // Clock starts low so the first event is a rising edge half a period in
    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk_o = ~clk_o;
        end
    end

    // Reset is a DUT input, so it changes on a falling edge like the rest of the stimulus
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule : tb_clock_gen

`default_nettype wire

// ==== tests/tb_exec_top.sv ====
// Runs tests/exec_vectors.txt three times so tags wrap; every pass must write each register it reads
`timescale 1ns/100ps
`default_nettype none

module tb_exec_top;

    localparam int BUFFER_DEPTH = 8;
    localparam int PASSES       = 3;
    localparam int MAX_CMDS     = 128;
    localparam int STALL_LIMIT  = 8;

    logic        clk;
    logic        rst_n;
    logic        flush;
    logic        instr_valid;
    logic [2:0]  instr_op;
    logic [4:0]  instr_rd;
    logic [4:0]  instr_rs1;
    logic [4:0]  instr_rs2;
    logic [31:0] instr_imm;
    logic        issue_ready;
    logic        retire_en;
    logic        retire_valid;
    logic [4:0]  retire_rd;
    logic [5:0]  retire_tag;
    logic [31:0] retire_data;

    // Parsed vector program with one entry per command line
    logic [7:0]  cmd_arr [MAX_CMDS];
    logic [31:0] op_arr  [MAX_CMDS];
    logic [31:0] rd_arr  [MAX_CMDS];
    logic [31:0] rs1_arr [MAX_CMDS];
    logic [31:0] rs2_arr [MAX_CMDS];
    logic [31:0] imm_arr [MAX_CMDS];
    logic [31:0] exp_arr [MAX_CMDS];
    int          num_cmds;

    // Expected retire stream in acceptance order with the oldest first
    logic [31:0] exp_data_q [$];
    logic [4:0]  exp_rd_q [$];
    logic [5:0]  exp_tag_q [$];
    logic [31:0] exp_data;
    logic [4:0]  exp_rd;
    logic [5:0]  exp_tag;

    // Model state of the issue side
    logic [5:0]  next_tag;
    int          held_accepts;
    logic        pend_valid;
    logic [31:0] pend_data;
    logic [4:0]  pend_rd;

    int          errors;
    int          retires_checked;
    int          tag_wraps;
    logic [5:0]  last_tag;
    int          cycle_cnt;
    int          timeout_cycles;

    tb_clock_gen #(
        .PERIOD_NS    (100),
        .RESET_CYCLES (8)
    ) u_clk_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    exec_top #(
        .BUFFER_DEPTH (BUFFER_DEPTH)
    ) exec_top_i (
        .clk_i          (clk),
        .rst_n_i        (rst_n),
        .flush_i        (flush),
        .instr_valid_i  (instr_valid),
        .instr_op_i     (instr_op),
        .instr_rd_i     (instr_rd),
        .instr_rs1_i    (instr_rs1),
        .instr_rs2_i    (instr_rs2),
        .instr_imm_i    (instr_imm),
        .issue_ready_o  (issue_ready),
        .retire_en_i    (retire_en),
        .retire_valid_o (retire_valid),
        .retire_rd_o    (retire_rd),
        .retire_tag_o   (retire_tag),
        .retire_data_o  (retire_data)
    );

    // ========================================================================
    // Vector file parsing
    // ========================================================================

    // Lines starting with # are skipped; I lines carry six hex fields
    task automatic load_vectors();
        int               fd;
        int               n;
        logic [7:0]       ch;
        logic [8*160-1:0] skip_line;
        logic [31:0]      f_op;
        logic [31:0]      f_rd;
        logic [31:0]      f_rs1;
        logic [31:0]      f_rs2;
        logic [31:0]      f_imm;
        logic [31:0]      f_exp;
        fd = $fopen("tests/exec_vectors.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the vector file tests/exec_vectors.txt");
            errors++;
        end else begin
            n = $fscanf(fd, " %c", ch);
            while (n == 1) begin
                if (ch == "#") begin
                    n = $fgets(skip_line, fd);
                end else begin
                    f_op  = '0;
                    f_rd  = '0;
                    f_rs1 = '0;
                    f_rs2 = '0;
                    f_imm = '0;
                    f_exp = '0;
                    if (ch == "I") begin
                        n = $fscanf(fd, "%h %h %h %h %h %h",
                                    f_op, f_rd, f_rs1, f_rs2, f_imm, f_exp);
                        if (n != 6) begin
                            $display("Malformed issue line %0d in the vector file", num_cmds);
                            errors++;
                        end
                    end else if (ch != "H" && ch != "R" && ch != "F" && ch != "W") begin
                        $display("Unknown command %s in the vector file", ch);
                        errors++;
                    end
                    if (num_cmds < MAX_CMDS) begin
                        cmd_arr[num_cmds] = ch;
                        op_arr[num_cmds]  = f_op;
                        rd_arr[num_cmds]  = f_rd;
                        rs1_arr[num_cmds] = f_rs1;
                        rs2_arr[num_cmds] = f_rs2;
                        imm_arr[num_cmds] = f_imm;
                        exp_arr[num_cmds] = f_exp;
                        num_cmds++;
                    end else begin
                        $display("Vector file has more than %0d commands", MAX_CMDS);
                        errors++;
                    end
                end
                n = $fscanf(fd, " %c", ch);
            end
            $fclose(fd);
        end
    endtask

    // ========================================================================
    // Issue side
    // ========================================================================

    // Called on the falling edge after the accepting rising edge
    task automatic record_accept(input logic [31:0] data, input logic [4:0] rd);
        if (!retire_en) begin
            // Fetch stage, ALU hold register and every buffer entry are all there is
            assert (held_accepts < BUFFER_DEPTH + 2) else begin
                $display("Issue accepted beyond %0d instructions while retire was held",
                         BUFFER_DEPTH + 2);
                errors++;
            end
            held_accepts++;
        end
        exp_data_q.push_back(data);
        exp_rd_q.push_back(rd);
        exp_tag_q.push_back(next_tag);
        next_tag++;
    endtask

    task automatic issue_instr(input int c);
        int stall;
        instr_valid = 1'b1;
        instr_op    = op_arr[c][2:0];
        instr_rd    = rd_arr[c][4:0];
        instr_rs1   = rs1_arr[c][4:0];
        instr_rs2   = rs2_arr[c][4:0];
        instr_imm   = imm_arr[c];
        stall       = 0;
        // Ready is stable from one falling edge to the next rising edge
        while (!issue_ready && (retire_en || stall < STALL_LIMIT)) begin
            @(negedge clk);
            stall++;
        end
        if (issue_ready) begin
            @(negedge clk);
            record_accept(exp_arr[c], rd_arr[c][4:0]);
            instr_valid = 1'b0;
            if ($urandom % 4 == 0) begin
                repeat (1 + $urandom % 2) @(negedge clk);
            end
        end else begin
            // Ready stayed low with retire held, so every slot must be occupied
            assert (held_accepts == BUFFER_DEPTH + 2) else begin
                $display("Issue refused after %0d accepts with retire held, expected %0d",
                         held_accepts, BUFFER_DEPTH + 2);
                errors++;
            end
            // The refused instruction stays on the port until it is taken
            pend_valid = 1'b1;
            pend_data  = exp_arr[c];
            pend_rd    = rd_arr[c][4:0];
        end
    endtask

    task automatic complete_pending();
        if (pend_valid) begin
            while (!issue_ready) begin
                @(negedge clk);
            end
            @(negedge clk);
            record_accept(pend_data, pend_rd);
            instr_valid = 1'b0;
            pend_valid  = 1'b0;
        end
    endtask

    task automatic drain_pipeline();
        complete_pending();
        instr_valid = 1'b0;
        while (exp_tag_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    // Flushed instructions never retire, and the tag counter keeps counting
    task automatic pulse_flush();
        complete_pending();
        instr_valid = 1'b0;
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        exp_data_q.delete();
        exp_rd_q.delete();
        exp_tag_q.delete();
        held_accepts = 0;
    endtask

    task automatic run_command(input int c);
        case (cmd_arr[c])
            "I": begin
                complete_pending();
                issue_instr(c);
            end
            "H": begin
                retire_en    = 1'b0;
                held_accepts = 0;
            end
            "R": begin
                retire_en = 1'b1;
                complete_pending();
            end
            "F": pulse_flush();
            "W": drain_pipeline();
            default: begin
                $display("Command %0d cannot be run", c);
                errors++;
            end
        endcase
    endtask

    task automatic print_summary();
        $display("Summary: %0d retires checked, %0d tag wraps, %0d errors",
                 retires_checked, tag_wraps, errors);
    endtask

    // ========================================================================
    // Retire monitor and timeout
    // ========================================================================

    // Samples before the edge updates land, so the head seen here is the one retiring
    always @(posedge clk) begin
        if (rst_n && retire_valid) begin
            assert (exp_tag_q.size() != 0) else begin
                $display("Retire of tag %h with no instruction outstanding", retire_tag);
                errors++;
            end
            if (exp_tag_q.size() != 0) begin
                exp_tag  = exp_tag_q.pop_front();
                exp_rd   = exp_rd_q.pop_front();
                exp_data = exp_data_q.pop_front();
                assert (retire_tag == exp_tag) else begin
                    $display("Mismatch retire_tag_o: got %h expected %h", retire_tag, exp_tag);
                    errors++;
                end
                assert (retire_rd == exp_rd) else begin
                    $display("Mismatch retire_rd_o: got %h expected %h (tag %h)",
                             retire_rd, exp_rd, exp_tag);
                    errors++;
                end
                assert (retire_data == exp_data) else begin
                    $display("Mismatch retire_data_o: got %h expected %h (tag %h)",
                             retire_data, exp_data, exp_tag);
                    errors++;
                end
                if (last_tag == 6'h3f && retire_tag == 6'h00) begin
                    tag_wraps++;
                end
                last_tag = retire_tag;
                retires_checked++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (timeout_cycles > 0 && cycle_cnt > timeout_cycles) begin
            $display("Timeout after %0d cycles with %0d retires outstanding",
                     cycle_cnt, exp_tag_q.size());
            print_summary();
            $display("TB FAILED");
            $finish;
        end
    end

    // ========================================================================
    // Main sequence
    // ========================================================================

    initial begin
        flush           = 1'b0;
        instr_valid     = 1'b0;
        instr_op        = '0;
        instr_rd        = '0;
        instr_rs1       = '0;
        instr_rs2       = '0;
        instr_imm       = '0;
        retire_en       = 1'b1;
        errors          = 0;
        retires_checked = 0;
        tag_wraps       = 0;
        last_tag        = '0;
        next_tag        = '0;
        held_accepts    = 0;
        pend_valid      = 1'b0;
        pend_data       = '0;
        pend_rd         = '0;
        cycle_cnt       = 0;
        timeout_cycles  = 0;
        num_cmds        = 0;
        void'($urandom(70143));

        load_vectors();
        timeout_cycles = num_cmds * PASSES * 30 + 200;

        wait (rst_n === 1'b1);
        @(negedge clk);
        assert (!retire_valid) else begin
            $display("Mismatch retire_valid_o: got %h expected 0 after reset", retire_valid);
            errors++;
        end
        assert (issue_ready) else begin
            $display("Mismatch issue_ready_o: got %h expected 1 after reset", issue_ready);
            errors++;
        end

        for (int p = 0; p < PASSES; p++) begin
            for (int c = 0; c < num_cmds; c++) begin
                run_command(c);
            end
        end
        drain_pipeline();

        assert (tag_wraps > 0) else begin
            $display("Retire tag never wrapped from 3f to 00");
            errors++;
        end

        print_summary();
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule : tb_exec_top

`default_nettype wire
